//--- common/msg_pkg.sv
package msg_pkg;

	// ####################################################################
	// message format
	// ####################################################################

	localparam int LANE_ID_NBITS = 2; // four lanes at most
	localparam int MSG_DATA_NBITS = 16;

	typedef struct packed {
		logic [LANE_ID_NBITS-1:0] dest; // lane the message is steered to
		logic [MSG_DATA_NBITS-1:0] data;
	} msg_t;

	// ####################################################################
	// queue behavior codes
	// ####################################################################

	localparam int QUEUE_TYPE_NBITS = 4;

	// bit 0 turns on pipe mode and bit 1 turns on bypass mode
	localparam logic [QUEUE_TYPE_NBITS-1:0] QUEUE_NORMAL = 4'b0000;
	localparam logic [QUEUE_TYPE_NBITS-1:0] QUEUE_PIPE = 4'b0001;
	localparam logic [QUEUE_TYPE_NBITS-1:0] QUEUE_BYPASS = 4'b0010;

endpackage

//--- queue/queue_ctrl.sv
`timescale 1ns/1ps

module queue_ctrl #(
	parameter logic [msg_pkg::QUEUE_TYPE_NBITS-1:0] p_type = msg_pkg::QUEUE_NORMAL,
	parameter int p_num_msgs = 4,
	localparam int c_addr_nbits = (p_num_msgs > 1) ? $clog2(p_num_msgs) : 1,
	localparam int c_cnt_nbits = $clog2(p_num_msgs + 1)
) (
	input logic clk,
	input logic arst_n,
	input logic enq_val,
	output logic enq_rdy,
	output logic deq_val,
	input logic deq_rdy,
	output logic write_en,
	output logic [c_addr_nbits-1:0] write_addr,
	output logic [c_addr_nbits-1:0] read_addr,
	output logic bypass_mux_sel,
	output logic [c_cnt_nbits-1:0] num_free_entries
);
	import msg_pkg::*;

	localparam logic c_pipe_en = |(p_type & QUEUE_PIPE);
	localparam logic c_bypass_en = |(p_type & QUEUE_BYPASS);

	logic [c_addr_nbits-1:0] enq_ptr;
	logic [c_addr_nbits-1:0] deq_ptr;
	logic [c_addr_nbits-1:0] enq_ptr_inc;
	logic [c_addr_nbits-1:0] deq_ptr_inc;
	logic full;
	logic empty;
	logic do_enq;
	logic do_deq;
	logic do_pipe;
	logic do_bypass;

	// pointers wrap at the depth, which need not be a power of two
	function automatic logic [c_addr_nbits-1:0] wrap_inc(input logic [c_addr_nbits-1:0] ptr);
		if (ptr == c_addr_nbits'(p_num_msgs - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// ####################################################################
	// handshake and mode rules
	// ####################################################################

	assign empty = !full && (enq_ptr == deq_ptr);
	assign do_enq = enq_val && enq_rdy;
	assign do_deq = deq_val && deq_rdy;

	assign do_pipe = c_pipe_en && full && do_enq && do_deq;
	assign do_bypass = c_bypass_en && empty && do_enq && do_deq; // message never lands in storage

	assign enq_rdy = !full || (c_pipe_en && full && deq_rdy);
	assign deq_val = !empty || (c_bypass_en && empty && enq_val);

	assign write_en = do_enq && !do_bypass;
	assign write_addr = enq_ptr;
	assign read_addr = deq_ptr;
	assign bypass_mux_sel = empty; // only matters when bypass can raise deq_val

	assign enq_ptr_inc = wrap_inc(enq_ptr);
	assign deq_ptr_inc = wrap_inc(deq_ptr);

	// ####################################################################
	// pointer and full state
	// ####################################################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			enq_ptr <= '0;
			deq_ptr <= '0;
			full <= 1'b0;
		end else begin
			if (do_enq && !do_bypass) begin
				enq_ptr <= enq_ptr_inc;
			end
			if (do_deq && !do_bypass) begin
				deq_ptr <= deq_ptr_inc;
			end
			if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr)) begin
				full <= 1'b1; // last free slot just taken
			end else if (do_deq && full && !do_pipe) begin
				full <= 1'b0;
			end
		end
	end

	// equal pointers mean empty unless the full flag is set
	always_comb begin
		if (full) begin
			num_free_entries = '0;
		end else if (enq_ptr >= deq_ptr) begin
			num_free_entries = c_cnt_nbits'(p_num_msgs) - c_cnt_nbits'(enq_ptr - deq_ptr);
		end else begin
			num_free_entries = c_cnt_nbits'(deq_ptr - enq_ptr);
		end
	end

endmodule

//--- queue/queue_dpath.sv
`timescale 1ns/1ps

module queue_dpath #(
	parameter int p_num_msgs = 4,
	localparam int c_addr_nbits = (p_num_msgs > 1) ? $clog2(p_num_msgs) : 1
) (
	input logic clk,
	input logic write_en,
	input logic [c_addr_nbits-1:0] write_addr,
	input logic [c_addr_nbits-1:0] read_addr,
	input logic bypass_mux_sel,
	input msg_pkg::msg_t enq_msg,
	output msg_pkg::msg_t deq_msg
);
	import msg_pkg::*;

	// ####################################################################
	// message storage
	// ####################################################################

	msg_t msg_regs [p_num_msgs];
	msg_t head_msg;

	always_ff @(posedge clk) begin
		if (write_en) begin
			msg_regs[write_addr] <= enq_msg;
		end
	end

	assign head_msg = msg_regs[read_addr];

	// ####################################################################
	// output select
	// ####################################################################

	// an empty queue in bypass mode hands the incoming message straight out
	always_comb begin
		if (bypass_mux_sel) begin
			deq_msg = enq_msg;
		end else begin
			deq_msg = head_msg;
		end
	end

endmodule

//--- queue/msg_queue.sv
`timescale 1ns/1ps

module msg_queue #(
	parameter logic [msg_pkg::QUEUE_TYPE_NBITS-1:0] p_type = msg_pkg::QUEUE_NORMAL,
	parameter int p_num_msgs = 4,
	localparam int c_addr_nbits = (p_num_msgs > 1) ? $clog2(p_num_msgs) : 1,
	localparam int c_cnt_nbits = $clog2(p_num_msgs + 1)
) (
	input logic clk,
	input logic arst_n,
	input logic enq_val,
	output logic enq_rdy,
	input msg_pkg::msg_t enq_msg,
	output logic deq_val,
	input logic deq_rdy,
	output msg_pkg::msg_t deq_msg,
	output logic [c_cnt_nbits-1:0] num_free_entries
);

	// storage controls stay inside the lane buffer
	logic write_en;
	logic [c_addr_nbits-1:0] write_addr;
	logic [c_addr_nbits-1:0] read_addr;
	logic bypass_mux_sel;

	// ####################################################################
	// control
	// ####################################################################

	queue_ctrl #(
		.p_type(p_type),
		.p_num_msgs(p_num_msgs)
	) ctrl_i (
		.clk(clk),
		.arst_n(arst_n),
		.enq_val(enq_val),
		.enq_rdy(enq_rdy),
		.deq_val(deq_val),
		.deq_rdy(deq_rdy),
		.write_en(write_en),
		.write_addr(write_addr),
		.read_addr(read_addr),
		.bypass_mux_sel(bypass_mux_sel),
		.num_free_entries(num_free_entries)
	);

	// ####################################################################
	// datapath
	// ####################################################################

	queue_dpath #(
		.p_num_msgs(p_num_msgs)
	) dpath_i (
		.clk(clk),
		.write_en(write_en),
		.write_addr(write_addr),
		.read_addr(read_addr),
		.bypass_mux_sel(bypass_mux_sel),
		.enq_msg(enq_msg),
		.deq_msg(deq_msg)
	);

endmodule

//--- design/lane_dispatch.sv
`timescale 1ns/1ps

module lane_dispatch #(
	parameter int p_num_lanes = 4
) (
	input logic in_val,
	output logic in_rdy,
	input msg_pkg::msg_t in_msg,
	output logic [p_num_lanes-1:0] enq_val,
	input logic [p_num_lanes-1:0] enq_rdy,
	output msg_pkg::msg_t enq_msg
);
	import msg_pkg::*;

	logic [p_num_lanes-1:0] lane_sel;

	// ####################################################################
	// destination decode
	// ####################################################################

	// a dest at or above p_num_lanes matches no lane and stays unaccepted
	always_comb begin
		lane_sel = '0;
		for (int i = 0; i < p_num_lanes; i++) begin
			if (in_msg.dest == LANE_ID_NBITS'(i)) begin
				lane_sel[i] = 1'b1;
			end
		end
	end

	// ####################################################################
	// handshake steering
	// ####################################################################

	assign enq_val = lane_sel & {p_num_lanes{in_val}};
	assign in_rdy = |(lane_sel & enq_rdy); // ready of the addressed lane only
	assign enq_msg = in_msg; // every lane sees the message, only one gets valid

endmodule

//--- design/lane_arbiter.sv
`timescale 1ns/1ps

module lane_arbiter #(
	parameter int p_num_lanes = 4,
	localparam int c_lane_nbits = (p_num_lanes > 1) ? $clog2(p_num_lanes) : 1
) (
	input logic clk,
	input logic arst_n,
	input logic [p_num_lanes-1:0] deq_val,
	output logic [p_num_lanes-1:0] deq_rdy,
	input msg_pkg::msg_t [p_num_lanes-1:0] deq_msg,
	output logic out_val,
	input logic out_rdy,
	output msg_pkg::msg_t out_msg
);

	logic [c_lane_nbits-1:0] prio_ptr;
	logic [c_lane_nbits-1:0] grant_idx;
	logic [c_lane_nbits-1:0] grant_idx_inc;
	logic [p_num_lanes-1:0] grant;
	logic found;

	// ####################################################################
	// grant search
	// ####################################################################

	// the search walks round the ring from the pointer to the first valid lane
	always_comb begin
		int idx;
		grant = '0;
		grant_idx = '0;
		found = 1'b0;
		for (int off = 0; off < p_num_lanes; off++) begin
			idx = int'(prio_ptr) + off;
			if (idx >= p_num_lanes) begin
				idx = idx - p_num_lanes;
			end
			if (!found && deq_val[idx]) begin
				found = 1'b1;
				grant[idx] = 1'b1;
				grant_idx = c_lane_nbits'(idx);
			end
		end
	end

	assign out_val = found;
	assign out_msg = deq_msg[grant_idx];
	assign deq_rdy = grant & {p_num_lanes{out_rdy}};

	// ####################################################################
	// priority pointer
	// ####################################################################

	assign grant_idx_inc = (grant_idx == c_lane_nbits'(p_num_lanes - 1)) ? '0 : grant_idx + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prio_ptr <= '0;
		end else if (out_val && out_rdy) begin
			prio_ptr <= grant_idx_inc; // winner drops to lowest priority
		end
	end

endmodule

//--- design/lane_switch.sv
`timescale 1ns/1ps

module lane_switch #(
	parameter int p_num_lanes = 4,
	parameter int p_num_msgs = 4,
	parameter logic [msg_pkg::QUEUE_TYPE_NBITS-1:0] p_queue_type = msg_pkg::QUEUE_NORMAL,
	localparam int c_cnt_nbits = $clog2(p_num_msgs + 1)
) (
	input logic clk,
	input logic arst_n,
	input logic in_val,
	output logic in_rdy,
	input msg_pkg::msg_t in_msg,
	output logic out_val,
	input logic out_rdy,
	output msg_pkg::msg_t out_msg,
	output logic [p_num_lanes-1:0][c_cnt_nbits-1:0] lane_free
);
	import msg_pkg::*;

	logic [p_num_lanes-1:0] enq_val;
	logic [p_num_lanes-1:0] enq_rdy;
	msg_t enq_msg;
	logic [p_num_lanes-1:0] deq_val;
	logic [p_num_lanes-1:0] deq_rdy;
	msg_t [p_num_lanes-1:0] deq_msg;

	// ####################################################################
	// input steering
	// ####################################################################

	lane_dispatch #(
		.p_num_lanes(p_num_lanes)
	) dispatch_i (
		.in_val(in_val),
		.in_rdy(in_rdy),
		.in_msg(in_msg),
		.enq_val(enq_val),
		.enq_rdy(enq_rdy),
		.enq_msg(enq_msg)
	);

	// ####################################################################
	// lane queues
	// ####################################################################

	for (genvar i = 0; i < p_num_lanes; i++) begin : g_lane
		msg_queue #(
			.p_type(p_queue_type),
			.p_num_msgs(p_num_msgs)
		) queue_i (
			.clk(clk),
			.arst_n(arst_n),
			.enq_val(enq_val[i]),
			.enq_rdy(enq_rdy[i]),
			.enq_msg(enq_msg),
			.deq_val(deq_val[i]),
			.deq_rdy(deq_rdy[i]),
			.deq_msg(deq_msg[i]),
			.num_free_entries(lane_free[i]) // credit count for upstream
		);
	end

	// ####################################################################
	// output merge
	// ####################################################################

	lane_arbiter #(
		.p_num_lanes(p_num_lanes)
	) arbiter_i (
		.clk(clk),
		.arst_n(arst_n),
		.deq_val(deq_val),
		.deq_rdy(deq_rdy),
		.deq_msg(deq_msg),
		.out_val(out_val),
		.out_rdy(out_rdy),
		.out_msg(out_msg)
	);

endmodule

//--- dv/lane_switch_tb.sv
`timescale 1ns/1ps

module lane_switch_tb;
	import msg_pkg::*;

	localparam int c_num_lanes = 4;
	localparam int c_num_msgs = 4;
	localparam int c_cnt_nbits = $clog2(c_num_msgs + 1);

	localparam int c_reset_cycles = 5;
	localparam int c_rand_cycles = 400;
	localparam int c_fill_cycles = 60;
	localparam int c_recover_cycles = 200;
	localparam int c_drain_cycles = 64;
	localparam int c_tail_cycles = 4;
	localparam int c_total_cycles = c_reset_cycles + 2 + c_rand_cycles + c_fill_cycles
		+ c_recover_cycles + c_drain_cycles + c_tail_cycles;
	localparam int c_timeout_ns = c_total_cycles * 20 + 200;

	logic clk;
	logic arst_n;
	logic in_val;
	logic in_rdy;
	msg_t in_msg;
	logic out_val;
	logic out_rdy;
	msg_t out_msg;
	logic [c_num_lanes-1:0][c_cnt_nbits-1:0] lane_free;

	msg_t model_q [c_num_lanes][$]; // expected contents of each lane
	int model_ptr; // round-robin pointer of the model
	logic monitor_on;
	logic in_pending; // input message offered but not yet taken
	int sent_cnt;
	int out_cnt;
	int msg_errs;
	int free_errs;
	int rdy_errs;
	int other_errs;

	lane_switch #(
		.p_num_lanes(c_num_lanes),
		.p_num_msgs(c_num_msgs),
		.p_queue_type(QUEUE_NORMAL)
	) lane_switch_i (
		.clk(clk),
		.arst_n(arst_n),
		.in_val(in_val),
		.in_rdy(in_rdy),
		.in_msg(in_msg),
		.out_val(out_val),
		.out_rdy(out_rdy),
		.out_msg(out_msg),
		.lane_free(lane_free)
	);

	always #10 clk = ~clk;

	// ####################################################################
	// compare tasks and model helpers
	// ####################################################################

	task automatic check_msg(input string name, input msg_t exp, input msg_t act);
		if (exp !== act) begin
			$display("** Error: %s expected 0x%h actual 0x%h at time %0d", name, exp, act, $time);
			msg_errs++;
		end
	endtask

	task automatic check_free(input string name, input logic [c_cnt_nbits-1:0] exp,
		input logic [c_cnt_nbits-1:0] act);
		if (exp !== act) begin
			$display("** Error: %s expected 0x%h actual 0x%h at time %0d", name, exp, act, $time);
			free_errs++;
		end
	endtask

	task automatic check_rdy(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error: %s expected 0x%h actual 0x%h at time %0d", name, exp, act, $time);
			rdy_errs++;
		end
	endtask

	// returns the first non-empty lane at or after the model pointer or -1 when all are empty
	function automatic int next_grant();
		int lane;
		for (int off = 0; off < c_num_lanes; off++) begin
			lane = (model_ptr + off) % c_num_lanes;
			if (model_q[lane].size() != 0) begin
				return lane;
			end
		end
		return -1;
	endfunction

	function automatic int model_total();
		int total;
		total = 0;
		for (int l = 0; l < c_num_lanes; l++) begin
			total += model_q[l].size();
		end
		return total;
	endfunction

	function automatic msg_t random_msg();
		msg_t m;
		m.dest = LANE_ID_NBITS'($urandom % c_num_lanes);
		m.data = MSG_DATA_NBITS'($urandom);
		return m;
	endfunction

	// a held message keeps its valid and payload until it is taken
	task automatic drive_inputs(input int in_pct, input int out_pct);
		if (!in_pending) begin
			in_val <= (($urandom % 100) < in_pct);
			in_msg <= random_msg();
		end
		out_rdy <= (($urandom % 100) < out_pct);
	endtask

	task automatic run_traffic(input int cycles, input int in_pct, input int out_pct);
		repeat (cycles) begin
			@(posedge clk);
			drive_inputs(in_pct, out_pct);
		end
	endtask

	// ####################################################################
	// the monitor samples at the falling edge where outputs are stable
	// ####################################################################

	always @(negedge clk) begin
		int exp_lane;
		logic lane_room;
		if (monitor_on) begin
			for (int l = 0; l < c_num_lanes; l++) begin
				check_free($sformatf("lane_free[%0d]", l),
					c_cnt_nbits'(c_num_msgs - model_q[l].size()), lane_free[l]);
			end
			exp_lane = next_grant();
			check_rdy("out_val", exp_lane >= 0, out_val);
			if (in_val) begin
				lane_room = (int'(in_msg.dest) < c_num_lanes)
					&& (model_q[in_msg.dest].size() < c_num_msgs);
				check_rdy("in_rdy", lane_room, in_rdy);
			end
			if (out_val && out_rdy) begin
				out_cnt++; // transfer lands on the coming rising edge
				if (exp_lane >= 0) begin
					check_msg("out_msg", model_q[exp_lane][0], out_msg);
					void'(model_q[exp_lane].pop_front());
					model_ptr = (exp_lane + 1) % c_num_lanes;
				end
			end
			if (in_val && in_rdy) begin
				model_q[in_msg.dest].push_back(in_msg);
				sent_cnt++;
			end
			in_pending = in_val && !in_rdy;
		end
	end

	// ####################################################################
	// watchdog
	// ####################################################################

	initial begin
		#(c_timeout_ns);
		$display("watchdog expired, the run timed out before all messages drained");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ####################################################################
	// main sequence
	// ####################################################################

	initial begin
		void'($urandom(32'hc944));
		clk = 1'b0;
		arst_n = 1'b0;
		in_val = 1'b0;
		in_msg = '0;
		out_rdy = 1'b0;
		model_ptr = 0;
		monitor_on = 1'b0;
		in_pending = 1'b0;
		sent_cnt = 0;
		out_cnt = 0;
		msg_errs = 0;
		free_errs = 0;
		rdy_errs = 0;
		other_errs = 0;

		repeat (c_reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_rdy("out_val", 1'b0, out_val);
		check_rdy("in_rdy", 1'b1, in_rdy);
		for (int l = 0; l < c_num_lanes; l++) begin
			check_free($sformatf("lane_free[%0d]", l), c_cnt_nbits'(c_num_msgs), lane_free[l]);
		end
		@(posedge clk);
		monitor_on = 1'b1;

		run_traffic(c_rand_cycles, 60, 60); // mixed load
		run_traffic(c_fill_cycles, 100, 0); // output stalled so the lanes fill up
		run_traffic(c_recover_cycles, 50, 80);

		while (in_pending || model_total() != 0) begin
			@(posedge clk);
			drive_inputs(0, 100);
		end
		run_traffic(c_tail_cycles, 0, 100);

		if (out_cnt != sent_cnt) begin
			$display("message count mismatch, %0d accepted but %0d delivered", sent_cnt, out_cnt);
			other_errs++;
		end

		$display("errors: msg %0d, free %0d, rdy %0d, other %0d",
			msg_errs, free_errs, rdy_errs, other_errs);
		if (msg_errs + free_errs + rdy_errs + other_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- lane_switch.f
common/msg_pkg.sv
queue/queue_ctrl.sv
queue/queue_dpath.sv
queue/msg_queue.sv
design/lane_dispatch.sv
design/lane_arbiter.sv
design/lane_switch.sv
dv/lane_switch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the lane switch testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing -Wno-fatal \
	--top-module lane_switch_tb \
	-f lane_switch.f \
	-o lane_switch_sim \
	&& ./obj_dir/lane_switch_sim > "$log" 2>&1 \
	|| { cat "$log" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$log"

grep -q "TEST RESULT: FAIL" "$log" \
	&& { echo "simulation reported errors"; exit 1; } \
	|| { echo "simulation finished cleanly"; exit 0; }
